// File: src.f
common/qsnd_pkg.sv
source/qsnd_work_ram.sv
source/qsnd_bus_arbiter.sv
source/qsnd_bus_ctrl.sv
source/qsnd_mailbox.sv
source/qsnd_cpu_timing.sv
source/qsnd_sound_top.sv
bench/qsnd_tb.sv

// File: run.sh
#!/bin/sh
# build and run the sound glue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module qsnd_tb -o qsnd_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/qsnd_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// File: bench/qsnd_tb.sv
// sound glue testbench with directed tests over decode, work RAM, mailbox, CPU timing and takeover
module qsnd_tb;

    logic                 clk48;
    logic                 rst;
    logic                 cen8;
    qsnd_pkg::cpu_bus_t   cpu_bus;
    logic                 busak_n;
    qsnd_pkg::main_bus_t  main_bus;
    logic [7:0]           rom_data;
    logic                 rom_ok;
    logic                 dsp_pids_n;
    logic                 dsp_iack;
    logic [7:0]           cpu_din;
    logic [7:0]           main_din;
    logic                 main_busakn;
    logic                 busrq_n;
    logic                 int_n;
    logic                 cpu_cen;
    qsnd_pkg::rom_req_t   rom;
    qsnd_pkg::dsp_port_t  dsp;

    logic [15:0] lfsr_state;
    int          checks;
    int          errors;
    int          tests;
    int          test_errors;
    logic [3:0]  bank;          // bank value last written
    logic        dsp_rst_exp;

    qsnd_sound_top #(.irq_period(20)) qsnd_sound_top_i (
        .clk48       ( clk48       ),
        .rst         ( rst         ),
        .cen8        ( cen8        ),
        .cpu_bus     ( cpu_bus     ),
        .busak_n     ( busak_n     ),
        .main_bus    ( main_bus    ),
        .rom_data    ( rom_data    ),
        .rom_ok      ( rom_ok      ),
        .dsp_pids_n  ( dsp_pids_n  ),
        .dsp_iack    ( dsp_iack    ),
        .cpu_din     ( cpu_din     ),
        .main_din    ( main_din    ),
        .main_busakn ( main_busakn ),
        .busrq_n     ( busrq_n     ),
        .int_n       ( int_n       ),
        .cpu_cen     ( cpu_cen     ),
        .rom         ( rom         ),
        .dsp         ( dsp         )
    );

    initial begin
        clk48 = 1'b0;
        forever #50 clk48 = ~clk48;
    end

    // 16-bit Galois LFSR
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s: got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error t=%0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("error t=%0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rom(input qsnd_pkg::rom_req_t got, input qsnd_pkg::rom_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error t=%0t rom request: got addr %05h cs %b expected addr %05h cs %b",
                     $time, got.addr, got.cs, exp.addr, exp.cs);
        end
    endtask

    task automatic check_dsp(input qsnd_pkg::dsp_port_t got, input qsnd_pkg::dsp_port_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error t=%0t dsp port: got %04h irq %b rst %b expected %04h irq %b rst %b",
                     $time, got.pbus_in, got.irq, got.rst, exp.pbus_in, exp.irq, exp.rst);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // drives one CPU memory cycle for two edges and captures read data after decode
    task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic wr,
                             output logic [7:0] rdata, output qsnd_pkg::rom_req_t rreq);
        cpu_bus.addr   = addr;
        cpu_bus.dout   = data;
        cpu_bus.mreq_n = 1'b0;
        cpu_bus.rd_n   = wr;
        cpu_bus.wr_n   = ~wr;
        @(posedge clk48);
        #10;
        rdata = cpu_din;
        rreq  = rom;
        @(posedge clk48);
        #10;
        cpu_bus.mreq_n = 1'b1;   // addr and data stay put
        cpu_bus.rd_n   = 1'b1;
        cpu_bus.wr_n   = 1'b1;
        @(posedge clk48);
        #10;
    endtask

    task automatic cen_step(input logic m1, input logic iorq, output logic seen);
        cen8           = 1'b1;
        cpu_bus.m1_n   = m1;
        cpu_bus.iorq_n = iorq;
        #20;
        seen = cpu_cen;
        @(posedge clk48);
        #10;
        cen8           = 1'b0;
        cpu_bus.m1_n   = 1'b1;
        cpu_bus.iorq_n = 1'b1;
        @(posedge clk48);
        #10;
    endtask

    task automatic test_reset_state();
        check_bit("int_n after reset", int_n, 1'b1);
        check_bit("main_busakn after reset", main_busakn, 1'b1);
        check_bit("busrq_n after reset", busrq_n, 1'b1);
        check_bit("dsp rst after reset", dsp.rst, 1'b1);
        check_bit("dsp irq after reset", dsp.irq, 1'b0);
        check_bit("rom cs after reset", rom.cs, 1'b0);
        end_test("reset state");
    endtask

    task automatic test_rom_decode();
        logic [15:0]        a;
        logic [7:0]         rd;
        qsnd_pkg::rom_req_t rq;
        qsnd_pkg::rom_req_t exp;
        for (int i = 0; i < 4; i++) begin
            a        = rand_bits(15);   // fixed window
            rom_data = 8'(rand_bits(8));
            bus_cycle(a, 8'h00, 1'b0, rd, rq);
            exp.addr = 19'(a);
            exp.cs   = 1'b1;
            check_rom(rq, exp);
            check_byte("rom read data", rd, rom_data);
        end
        bank = 4'(rand_bits(4));
        bus_cycle(16'hd003, {4'h0, bank}, 1'b1, rd, rq);   // bit 7 clear
        check_bit("dsp rst with bit 7 clear", dsp.rst, dsp_rst_exp);
        for (int i = 0; i < 4; i++) begin
            a        = 16'h8000 | rand_bits(14);
            rom_data = 8'(rand_bits(8));
            bus_cycle(a, 8'h00, 1'b0, rd, rq);
            exp.addr = 19'(bank) * 19'd16384 + 19'(a[13:0]) + 19'h0_8000;
            exp.cs   = 1'b1;
            check_rom(rq, exp);
            check_byte("banked rom read data", rd, rom_data);
        end
        end_test("rom decode");
    endtask

    task automatic test_work_ram();
        logic [15:0]        addrs [4];
        logic [7:0]         model [logic [12:0]];
        logic [7:0]         d;
        logic [7:0]         rd;
        qsnd_pkg::rom_req_t rq;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = {(i % 2 == 0) ? 4'hc : 4'hf, 12'(rand_bits(12))};
            d        = 8'(rand_bits(8));
            model[addrs[i][12:0]] = d;   // later write wins on a repeat
            bus_cycle(addrs[i], d, 1'b1, rd, rq);
        end
        for (int i = 0; i < 4; i++) begin
            bus_cycle(addrs[i], 8'h00, 1'b0, rd, rq);
            check_byte("ram read back", rd, model[addrs[i][12:0]]);
        end
        bus_cycle({4'he, 12'(rand_bits(12))}, 8'h00, 1'b0, rd, rq);
        check_byte("unmapped read", rd, 8'hff);
        end_test("work ram");
    endtask

    task automatic test_bank_reg();
        logic [7:0]         rd;
        qsnd_pkg::rom_req_t rq;
        bank = 4'(rand_bits(4));
        bus_cycle(16'hd003, {4'h8, bank}, 1'b1, rd, rq);
        dsp_rst_exp = 1'b0;
        check_bit("dsp rst released", dsp.rst, dsp_rst_exp);
        bus_cycle(16'hd007, 8'h00, 1'b0, rd, rq);
        check_byte("status with bank", rd, {1'b1, 3'b111, bank});
        end_test("bank register");
    endtask

    task automatic test_mailbox();
        logic [7:0]          msb;
        logic [7:0]          lsb;
        logic [7:0]          ab;
        logic [7:0]          rd;
        qsnd_pkg::rom_req_t  rq;
        qsnd_pkg::dsp_port_t exp;
        msb = 8'(rand_bits(8));
        lsb = 8'(rand_bits(8));
        ab  = 8'(rand_bits(8));
        bus_cycle(16'hd000, msb, 1'b1, rd, rq);
        bus_cycle(16'hd001, lsb, 1'b1, rd, rq);
        bus_cycle(16'hd002, ab, 1'b1, rd, rq);   // address byte raises irq
        exp.pbus_in = {8'h00, ab};
        exp.irq     = 1'b1;
        exp.rst     = dsp_rst_exp;
        check_dsp(dsp, exp);
        bus_cycle(16'hd007, 8'h00, 1'b0, rd, rq);
        check_byte("status while busy", rd, {1'b0, 3'b111, bank});
        dsp_pids_n = 1'b0;
        @(posedge clk48);
        #10;
        dsp_pids_n = 1'b1;   // rising edge
        @(posedge clk48);
        #10;
        exp.pbus_in = {msb, lsb};
        exp.irq     = 1'b0;
        check_dsp(dsp, exp);
        dsp_iack = 1'b1;     // DSP still acknowledging
        bus_cycle(16'hd007, 8'h00, 1'b0, rd, rq);
        check_byte("status during iack", rd, {1'b0, 3'b111, bank});
        dsp_iack = 1'b0;
        bus_cycle(16'hd007, 8'h00, 1'b0, rd, rq);
        check_byte("status after pids", rd, {1'b1, 3'b111, bank});
        end_test("mailbox");
    endtask

    task automatic fetch_pulses(input logic [15:0] addr, input int n);
        logic seen;
        int   pulses;
        int   exp;
        pulses       = 0;
        cpu_bus.addr = addr;
        for (int i = 0; i < n; i++) begin
            cen_step((i == 0) ? 1'b0 : 1'b1, 1'b1, seen);   // fetch on the first step only
            pulses = pulses + (seen ? 1 : 0);
        end
        exp = n - ((addr[15:12] >= 4'h4) ? 1 : 0);
        check_count("cpu_cen pulses", pulses, exp);
    endtask

    task automatic test_cpu_timing();
        logic seen;
        int   steps;
        steps        = 0;
        cpu_bus.addr = 16'h0000;
        while (int_n && steps < 40) begin
            cen_step(1'b1, 1'b1, seen);
            steps++;
        end
        if (int_n) begin
            errors++;
            $display("timeout: int_n did not fall within 40 cen8 steps");
        end
        check_count("cen8 steps to int_n", steps, 20);
        cen_step(1'b0, 1'b0, seen);   // acknowledge cycle
        check_bit("int_n after acknowledge", int_n, 1'b1);
        fetch_pulses(16'h5000, 4);
        fetch_pulses(16'h1000, 4);
        end_test("cpu timing");
    endtask

    task automatic test_takeover();
        logic        seen;
        int          steps;
        logic [7:0]  d;
        logic [15:0] a;
        a                = {4'hc, 12'(rand_bits(12))};
        d                = 8'(rand_bits(8));
        main_bus.addr    = {7'd0, a};
        main_bus.ldswn   = 1'b1;
        main_bus.buse_n  = 1'b0;
        busak_n          = 1'b0;
        @(posedge clk48);
        #10;
        check_bit("busrq_n follows buse_n", busrq_n, 1'b0);
        steps = 0;
        while (main_busakn && steps < 10) begin
            cen_step(1'b1, 1'b1, seen);
            steps++;
        end
        if (main_busakn) begin
            errors++;
            $display("timeout: main CPU was not granted the bus within 10 cen8 steps");
        end
        check_count("cen8 steps to grant", steps, 2);
        main_bus.dout  = d;
        main_bus.ldswn = 1'b0;
        @(posedge clk48);
        #10;
        main_bus.ldswn = 1'b1;
        repeat (3) @(posedge clk48);
        #10;
        check_byte("main read back", main_din, d);
        main_bus.addr = 23'(rand_bits(15));   // fixed ROM window
        rom_ok        = 1'b0;
        @(posedge clk48);
        #10;
        check_bit("main_busakn while rom busy", main_busakn, 1'b1);
        rom_ok = 1'b1;
        @(posedge clk48);
        #10;
        check_bit("main_busakn once rom ready", main_busakn, 1'b0);
        main_bus.buse_n = 1'b1;
        busak_n         = 1'b1;
        @(posedge clk48);
        #10;
        check_bit("main_busakn after release", main_busakn, 1'b1);
        check_bit("busrq_n after release", busrq_n, 1'b1);
        end_test("bus takeover");
    endtask

    initial begin
        lfsr_state  = 16'd11;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        test_errors = 0;
        bank        = '0;
        dsp_rst_exp = 1'b1;
        rst         = 1'b1;
        cen8        = 1'b0;
        cpu_bus     = '{16'h0000, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
        busak_n     = 1'b1;
        main_bus    = '{23'h0, 8'h00, 1'b1, 1'b1};
        rom_data    = 8'h00;
        rom_ok      = 1'b1;
        dsp_pids_n  = 1'b1;
        dsp_iack    = 1'b0;
        repeat (2) @(posedge clk48);
        #10;
        rst = 1'b0;
        test_reset_state();
        test_rom_decode();
        test_work_ram();
        test_bank_reg();
        test_mailbox();
        test_cpu_timing();
        test_takeover();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: source/qsnd_sound_top.sv
// qsnd sound glue top: bus arbitration, decode, work RAM, DSP mailbox and CPU timing
module qsnd_sound_top #(
    parameter int irq_period = 32000
) (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 cen8,
    input  qsnd_pkg::cpu_bus_t   cpu_bus,
    input  logic                 busak_n,
    input  qsnd_pkg::main_bus_t  main_bus,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    input  logic                 dsp_pids_n,
    input  logic                 dsp_iack,
    output logic [7:0]           cpu_din,
    output logic [7:0]           main_din,
    output logic                 main_busakn,
    output logic                 busrq_n,
    output logic                 int_n,
    output logic                 cpu_cen,
    output qsnd_pkg::rom_req_t   rom,
    output qsnd_pkg::dsp_port_t  dsp
);

    qsnd_pkg::mem_bus_t mem;
    logic [7:0] ram_q;
    logic       ram_we;
    logic       qsnd_wr;
    logic [1:0] wr_offset;
    logic       dsp_rst;
    logic       rom_stall;
    logic       dsp_busy;

    assign rom_stall = rom.cs & ~rom_ok;      // SDRAM still fetching
    assign dsp_busy  = dsp.irq | dsp_iack;

    // main CPU sees the same read data one cycle later
    always_ff @(posedge clk48) begin
        main_din <= cpu_din;
    end

    qsnd_bus_arbiter u_arbiter (
        .clk48       ( clk48       ),
        .rst         ( rst         ),
        .cen8        ( cen8        ),
        .cpu_bus     ( cpu_bus     ),
        .main_bus    ( main_bus    ),
        .busak_n     ( busak_n     ),
        .rom_stall   ( rom_stall   ),
        .mem         ( mem         ),
        .busrq_n     ( busrq_n     ),
        .main_busakn ( main_busakn )
    );

    qsnd_bus_ctrl u_ctrl (
        .clk48     ( clk48     ),
        .rst       ( rst       ),
        .mem       ( mem       ),
        .rom_data  ( rom_data  ),
        .ram_q     ( ram_q     ),
        .dsp_busy  ( dsp_busy  ),
        .rom       ( rom       ),
        .ram_we    ( ram_we    ),
        .qsnd_wr   ( qsnd_wr   ),
        .qsnd_rd   (           ),   // status strobe, only needed inside the controller
        .wr_offset ( wr_offset ),
        .dsp_rst   ( dsp_rst   ),
        .cpu_din   ( cpu_din   )
    );

    qsnd_work_ram #(.aw(qsnd_pkg::ram_aw)) u_ram (
        .clk48 ( clk48                          ),
        .addr  ( mem.addr[qsnd_pkg::ram_aw-1:0] ),
        .din   ( mem.din                        ),
        .we    ( ram_we                         ),
        .q     ( ram_q                          )
    );

    qsnd_mailbox u_mailbox (
        .clk48      ( clk48      ),
        .rst        ( rst        ),
        .qsnd_wr    ( qsnd_wr    ),
        .wr_offset  ( wr_offset  ),
        .din        ( mem.din    ),
        .dsp_rst    ( dsp_rst    ),
        .dsp_pids_n ( dsp_pids_n ),
        .dsp        ( dsp        )
    );

    qsnd_cpu_timing #(.irq_period(irq_period)) u_timing (
        .clk48   ( clk48                ),
        .rst     ( rst                  ),
        .cen8    ( cen8                 ),
        .m1_n    ( cpu_bus.m1_n         ),
        .iorq_n  ( cpu_bus.iorq_n       ),
        .page    ( cpu_bus.addr[15:12]  ),
        .int_n   ( int_n                ),
        .cpu_cen ( cpu_cen              )
    );

endmodule

// File: source/qsnd_cpu_timing.sv
// sound CPU timing: periodic interrupt with acknowledge and opcode-fetch wait step
module qsnd_cpu_timing #(
    parameter int irq_period = 32000
) (
    input  logic       clk48,
    input  logic       rst,
    input  logic       cen8,
    input  logic       m1_n,
    input  logic       iorq_n,
    input  logic [3:0] page,
    output logic       int_n,
    output logic       cpu_cen
);

    localparam int cnt_w = $clog2(irq_period);

    logic [cnt_w-1:0] cnt;
    logic             cnt_over;
    logic             stall;

    assign cnt_over = cnt == cnt_w'(irq_period - 1);

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= cnt_over ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;   // interrupt acknowledge cycle
            else if (cnt_over)
                int_n <= 1'b0;
        end
    end

    // one cen8 step lost on fetches from the upper pages
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst)
            stall <= 1'b0;
        else if (cen8) begin
            if (stall)
                stall <= 1'b0;
            else if (!m1_n && page >= qsnd_pkg::wait_page)
                stall <= 1'b1;
        end
    end

    assign cpu_cen = cen8 & ~stall;

endmodule

// File: source/qsnd_mailbox.sv
// CPU to DSP mailbox: 24-bit latch, DSP interrupt flag and parallel-bus data select
module qsnd_mailbox (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 qsnd_wr,
    input  logic [1:0]           wr_offset,
    input  logic [7:0]           din,
    input  logic                 dsp_rst,
    input  logic                 dsp_pids_n,
    output qsnd_pkg::dsp_port_t  dsp
);

    logic [23:0] cpu2dsp;   // address byte on top, data word below
    logic        irq;
    logic [1:0]  datasel;
    logic        last_pids_n;
    logic        pids_rise;

    assign pids_rise = dsp_pids_n && !last_pids_n;

    always_ff @(posedge clk48) begin
        if (qsnd_wr) begin
            case ({1'b0, wr_offset})
                qsnd_pkg::reg_data_msb: cpu2dsp[15:8]  <= din;
                qsnd_pkg::reg_data_lsb: cpu2dsp[7:0]   <= din;
                qsnd_pkg::reg_addr:     cpu2dsp[23:16] <= din;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            irq         <= 1'b0;
            datasel     <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp_pids_n;
            if (qsnd_wr && {1'b0, wr_offset} == qsnd_pkg::reg_addr) begin
                irq     <= 1'b1;    // address byte completes the message
                datasel <= 2'b11;
            end else if (pids_rise) begin
                irq     <= 1'b0;
                datasel <= datasel >> 1;
            end
        end
    end

    // DSP reads the address first, then the data word
    assign dsp.pbus_in = datasel[1] ? {8'd0, cpu2dsp[23:16]} : cpu2dsp[15:0];
    assign dsp.irq     = irq;
    assign dsp.rst     = dsp_rst;

endmodule

// File: source/qsnd_bus_ctrl.sv
// sound bus controller: registered address decode, bank and DSP reset register, read mux
module qsnd_bus_ctrl (
    input  logic                clk48,
    input  logic                rst,
    input  qsnd_pkg::mem_bus_t  mem,
    input  logic [7:0]          rom_data,
    input  logic [7:0]          ram_q,
    input  logic                dsp_busy,
    output qsnd_pkg::rom_req_t  rom,
    output logic                ram_we,
    output logic                qsnd_wr,
    output logic                qsnd_rd,
    output logic [1:0]          wr_offset,
    output logic                dsp_rst,
    output logic [7:0]          cpu_din
);

    logic [3:0]                   page;
    logic [2:0]                   offset;
    logic                         rom_cs, ram_cs, bank_cs;
    logic [qsnd_pkg::rom_aw-1:0]  rom_addr;
    logic [qsnd_pkg::bank_w-1:0]  bank;
    logic                         qsnd_hit;

    assign page     = mem.addr[15:12];
    assign offset   = mem.addr[2:0];
    assign qsnd_hit = !mem.mreqn && page == qsnd_pkg::qsnd_page;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            qsnd_wr <= 1'b0;
            bank_cs <= 1'b0;
            qsnd_rd <= 1'b0;
        end else begin
            rom_cs  <= !mem.mreqn && (!mem.addr[15] || mem.addr[15:14] == 2'b10);
            ram_cs  <= !mem.mreqn && (page == qsnd_pkg::ram_hi_a || page == qsnd_pkg::ram_hi_b);
            qsnd_wr <= qsnd_hit && !mem.wrn && offset <= qsnd_pkg::reg_addr;
            bank_cs <= qsnd_hit && !mem.wrn && offset == qsnd_pkg::reg_bank;
            qsnd_rd <= qsnd_hit && !mem.rdn && offset == qsnd_pkg::reg_status;
        end
    end

    // ROM address and mailbox offset follow the sampled cycle
    always_ff @(posedge clk48) begin
        if (!mem.mreqn) begin
            wr_offset <= offset[1:0];
            if (mem.addr[15])
                rom_addr <= {{(qsnd_pkg::rom_aw-qsnd_pkg::bank_w-14){1'b0}}, bank, mem.addr[13:0]}
                          + qsnd_pkg::bank_base;
            else
                rom_addr <= {{(qsnd_pkg::rom_aw-15){1'b0}}, mem.addr[14:0]};   // fixed window
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank    <= '0;
            dsp_rst <= 1'b1;   // DSP held in reset until the CPU releases it
        end else if (bank_cs) begin
            bank    <= mem.din[qsnd_pkg::bank_w-1:0];
            dsp_rst <= ~mem.din[7];
        end
    end

    assign ram_we   = ram_cs && !mem.wrn;
    assign rom.addr = rom_addr;
    assign rom.cs   = rom_cs;

    always_comb begin
        if (rom_cs)
            cpu_din = rom_data;
        else if (ram_cs)
            cpu_din = ram_q;
        else if (qsnd_rd)
            cpu_din = {~dsp_busy, {(7-qsnd_pkg::bank_w){1'b1}}, bank};   // status byte
        else
            cpu_din = 8'hff;   // open bus
    end

endmodule

// File: source/qsnd_bus_arbiter.sv
// bus arbiter: main CPU takeover of the sound bus and owner multiplexer
module qsnd_bus_arbiter (
    input  logic                 clk48,
    input  logic                 rst,
    input  logic                 cen8,
    input  qsnd_pkg::cpu_bus_t   cpu_bus,
    input  qsnd_pkg::main_bus_t  main_bus,
    input  logic                 busak_n,
    input  logic                 rom_stall,
    output qsnd_pkg::mem_bus_t   mem,
    output logic                 busrq_n,
    output logic                 main_busakn
);

    logic [1:0] latch;
    logic       main_own;   // low while the main CPU holds the bus

    assign busrq_n  = main_bus.buse_n;
    assign main_own = latch[1];

    // grant ripples through two cen8 steps, release is immediate
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst)
            latch <= 2'b11;
        else if (main_bus.buse_n)
            latch <= 2'b11;
        else if (cen8)
            latch <= {latch[0], busrq_n | busak_n};
    end

    assign main_busakn = main_own | rom_stall;

    always_comb begin
        if (main_own) begin
            mem.addr  = cpu_bus.addr;
            mem.din   = cpu_bus.dout;
            mem.wrn   = cpu_bus.wr_n;
            mem.rdn   = cpu_bus.rd_n;
            mem.mreqn = cpu_bus.mreq_n;
        end else begin
            mem.addr  = main_bus.addr[15:0];   // word address, low byte lane
            mem.din   = main_bus.dout;
            mem.wrn   = main_bus.ldswn;
            mem.rdn   = ~main_bus.ldswn;       // reads whenever not writing
            mem.mreqn = 1'b0;
        end
    end

endmodule

// File: source/qsnd_work_ram.sv
// sound CPU work RAM, single port, synchronous read and write
module qsnd_work_ram #(
    parameter int aw = 13
) (
    input  logic          clk48,
    input  logic [aw-1:0] addr,
    input  logic [7:0]    din,
    input  logic          we,
    output logic [7:0]    q
);

    logic [7:0] mem [2**aw];

    always_ff @(posedge clk48) begin
        if (we)
            mem[addr] <= din;
        q <= mem[addr];   // read data one cycle after address
    end

endmodule

// File: common/qsnd_pkg.sv
// qsnd sound glue package: bus structs, address map and widths
package qsnd_pkg;

    localparam int rom_aw = 19;   // 512 kB sound ROM
    localparam int ram_aw = 13;   // 8 kB work RAM
    localparam int bank_w = 4;

    localparam logic [rom_aw-1:0] bank_base = 19'h0_8000;   // banked ROM starts after fixed window

    // page nibbles on addr[15:12]
    localparam logic [3:0] ram_hi_a  = 4'hc;
    localparam logic [3:0] ram_hi_b  = 4'hf;
    localparam logic [3:0] qsnd_page = 4'hd;
    localparam logic [3:0] wait_page = 4'h4;   // opcode fetches from here up get a wait step

    // register offsets on addr[2:0]
    localparam logic [2:0] reg_data_msb = 3'd0;
    localparam logic [2:0] reg_data_lsb = 3'd1;
    localparam logic [2:0] reg_addr     = 3'd2;
    localparam logic [2:0] reg_bank     = 3'd3;
    localparam logic [2:0] reg_status   = 3'd7;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } cpu_bus_t;

    typedef struct packed {
        logic [22:0] addr;     // word address
        logic [7:0]  dout;
        logic        ldswn;
        logic        buse_n;
    } main_bus_t;

    // bus after arbitration
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  din;
        logic        wrn;
        logic        mreqn;
        logic        rdn;
    } mem_bus_t;

    typedef struct packed {
        logic [rom_aw-1:0] addr;
        logic              cs;
    } rom_req_t;

    typedef struct packed {
        logic [15:0] pbus_in;
        logic        irq;
        logic        rst;
    } dsp_port_t;

endpackage
